// File: Makefile
TOP := reprog_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: filelist.f
+incdir+hdl
hdl/reprog_pkg.sv
hdl/wb_reprog_regs.sv
hdl/boot_watchdog.sv
hdl/reprog_arbiter.sv
hdl/icap_sequencer.sv
hdl/reprog_top.sv
tb/reprog_tb.sv

// File: hdl/boot_watchdog.sv
`include "reprog_defs.svh"

module boot_watchdog (
	input  logic clk,
	input  logic reset,
	input  logic enable,     // from CTRL bit 2
	input  logic heartbeat,  // kick from the application
	output logic wdt_expire  // one clock pulse on timeout
);

	// ====================
	// timeout counter
	// ====================
	localparam int CW = $clog2(`REPROG_WDT_CYCLES + 1); // counter width

	logic [CW-1:0] cnt;    // cycles left before expiry
	logic          fired;  // blocks repeat pulses
	logic          reload; // restart the count

	assign reload = heartbeat | ~enable; // disabled counts as kicked

	// heartbeat edge loads N-1, zero is reached N-1 edges later and the
	// pulse is registered on the next edge, N cycles after the kick
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt        <= CW'(`REPROG_WDT_CYCLES - 1);
			fired      <= 1'b0;
			wdt_expire <= 1'b0;
		end else begin
			wdt_expire <= 1'b0; // default low
			if (reload) begin
				cnt <= CW'(`REPROG_WDT_CYCLES - 1);
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1; // count down, hold at zero
			end

			if (!enable) begin
				fired <= 1'b0; // rearm only through disable
			end else if (!heartbeat && (cnt == '0) && !fired) begin
				wdt_expire <= 1'b1; // single pulse
				fired      <= 1'b1;
			end
		end
	end

endmodule

// File: hdl/icap_sequencer.sv
`include "reprog_defs.svh"

module icap_sequencer import reprog_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        seq_go,     // start pulse from arbiter
	input  image_sel_t  seq_image,  // target image
	output logic        busy,       // high until reset once started
	output logic        icap_csib,  // active low ICAP select
	output logic [31:0] icap_data   // bit swapped config word
);

	typedef enum logic [3:0] {
		IDLE, SEND_WORD1, SEND_WORD2, SEND_WORD3, SEND_WORD4,
		SEND_WORD5, SEND_WORD6, SEND_WORD7, SEND_WORD8, DONE
	} seq_state_t;

	seq_state_t  state;
	logic [31:0] icap_word; // word in normal bit order
	image_sel_t  img_q;     // image latched at go

	// ====================
	// ICAP bit ordering
	// ====================
	// ICAP wants each byte mirrored, byte order unchanged
	for (genvar b = 0; b < 4; b++) begin : g_byte
		for (genvar k = 0; k < 8; k++) begin : g_bit
			assign icap_data[8*b + k] = icap_word[8*b + 7 - k];
		end
	end

	always_ff @(posedge clk) begin
		if ((state == IDLE) && seq_go) begin
			img_q <= seq_image;
		end
	end

	// ====================
	// command FSM
	// ====================
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= IDLE;
			icap_word <= `REPROG_ICAP_DUMMY;
			icap_csib <= 1'b1; // deselected
			busy      <= 1'b0;
		end else begin
			icap_csib <= 1'b0; // selected in every send state
			case (state)
				IDLE: begin
					icap_word <= `REPROG_ICAP_DUMMY;
					icap_csib <= 1'b1;
					if (seq_go) begin
						busy  <= 1'b1; // stays set until reset
						state <= SEND_WORD1;
					end
				end
				SEND_WORD1: begin
					icap_word <= `REPROG_ICAP_DUMMY;
					state     <= SEND_WORD2;
				end
				SEND_WORD2: begin
					icap_word <= `REPROG_ICAP_SYNC;
					state     <= SEND_WORD3;
				end
				SEND_WORD3: begin
					icap_word <= `REPROG_ICAP_NOOP;
					state     <= SEND_WORD4;
				end
				SEND_WORD4: begin
					icap_word <= `REPROG_ICAP_WRITE_WBSTAR;
					state     <= SEND_WORD5;
				end
				SEND_WORD5: begin
					// warm boot start address, upper byte zero
					icap_word <= {8'h00, (img_q == IMAGE_MASTER) ? `REPROG_MASTER_ADDR
					                                             : `REPROG_GOLDEN_ADDR};
					state     <= SEND_WORD6;
				end
				SEND_WORD6: begin
					icap_word <= `REPROG_ICAP_WRITE_CMD;
					state     <= SEND_WORD7;
				end
				SEND_WORD7: begin
					icap_word <= `REPROG_ICAP_IPROG;
					state     <= SEND_WORD8;
				end
				SEND_WORD8: begin
					icap_word <= `REPROG_ICAP_NOOP;
					state     <= DONE;
				end
				DONE: begin
					icap_word <= `REPROG_ICAP_NOOP;
					icap_csib <= 1'b1; // device reconfigures from here
				end
				default: begin
					icap_csib <= 1'b1;
					state     <= IDLE;
				end
			endcase
		end
	end

	// ====================
	// checks
	// ====================
	a_csib_burst: assert property (@(posedge clk) disable iff (reset)
		$fell(icap_csib) |-> !icap_csib [*8] ##1 icap_csib)
		else $error("icap_csib low burst not exactly 8 cycles");

endmodule

// File: hdl/reprog_arbiter.sv
module reprog_arbiter import reprog_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  logic          host_req,   // pulse from CTRL write
	input  image_sel_t    host_image, // image asked by host
	input  logic          wdt_expire, // pulse from watchdog
	input  logic          busy,       // sequencer running or done
	output logic          seq_go,     // one clock start pulse
	output image_sel_t    seq_image,  // image handed to sequencer
	output reboot_cause_t last_cause  // which source won
);

	// ====================
	// request merge
	// ====================
	logic issued;  // go already sent this reset
	logic req_any; // either source asking
	logic req_ok;  // request that will be honoured

	assign req_any = host_req | wdt_expire;
	assign req_ok  = req_any & ~busy & ~issued; // first request only

	// watchdog checked first, it always forces golden
	always_ff @(posedge clk) begin
		if (reset) begin
			seq_go     <= 1'b0;
			issued     <= 1'b0;
			seq_image  <= IMAGE_GOLDEN;
			last_cause <= CAUSE_NONE;
		end else begin
			seq_go <= req_ok; // one cycle behind request
			if (req_ok) begin
				issued <= 1'b1; // covers the cycle before busy rises
				if (wdt_expire) begin
					seq_image  <= IMAGE_GOLDEN;
					last_cause <= CAUSE_WATCHDOG;
				end else begin
					seq_image  <= host_image;
					last_cause <= CAUSE_HOST;
				end
			end
		end
	end

	// ====================
	// checks
	// ====================
	a_go_not_busy: assert property (@(posedge clk) disable iff (reset)
		!(seq_go && busy))
		else $error("seq_go raised while sequencer busy");

endmodule

// File: hdl/reprog_defs.svh
`ifndef REPROG_DEFS_SVH
`define REPROG_DEFS_SVH

// ====================
// icap command words
// ====================
`define REPROG_ICAP_DUMMY        32'hFFFF_FFFF // pad word before sync
`define REPROG_ICAP_SYNC         32'hAA99_5566 // sync word
`define REPROG_ICAP_NOOP         32'h2000_0000 // type 1 noop
`define REPROG_ICAP_WRITE_WBSTAR 32'h3002_0001 // type 1 write, 1 word to WBSTAR
`define REPROG_ICAP_WRITE_CMD    32'h3000_8001 // type 1 write, 1 word to CMD
`define REPROG_ICAP_IPROG        32'h0000_000F // IPROG command code

// ====================
// flash start addresses
// ====================
`define REPROG_GOLDEN_ADDR 24'h00_0000 // golden image at bottom of flash
`define REPROG_MASTER_ADDR 24'h40_0000 // master image, upper region

// ====================
// watchdog and bus map
// ====================
`define REPROG_WDT_CYCLES 64 // clocks without heartbeat before fallback

`define REPROG_ADR_CTRL   2'd0 // control word
`define REPROG_ADR_STATUS 2'd1 // status word, read only

`endif

// File: hdl/reprog_pkg.sv
package reprog_pkg;

	// ====================
	// image selection
	// ====================
	typedef enum logic {
		IMAGE_GOLDEN = 1'b0, // fallback image
		IMAGE_MASTER = 1'b1  // regular application image
	} image_sel_t;

	// ====================
	// reboot cause
	// ====================
	// held until reset, read back through STATUS bits 2..1
	typedef enum logic [1:0] {
		CAUSE_NONE     = 2'd0, // no reboot requested yet
		CAUSE_HOST     = 2'd1, // host write to CTRL
		CAUSE_WATCHDOG = 2'd2  // heartbeat lost
	} reboot_cause_t;

endpackage

// File: hdl/reprog_top.sv
module reprog_top import reprog_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	// wishbone classic slave
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [1:0]  wb_adr,
	input  logic [31:0] wb_dat_w,
	input  logic [3:0]  wb_sel,
	output logic [31:0] wb_dat_r,
	output logic        wb_ack,
	input  logic        heartbeat,  // application alive strobe
	// ICAP port
	output logic        icap_csib,
	output logic [31:0] icap_data
);

	// ====================
	// internal wiring
	// ====================
	logic          host_req;   // regs to arbiter
	image_sel_t    host_image;
	logic          wdt_enable; // regs to watchdog
	logic          wdt_expire; // watchdog to arbiter
	logic          seq_go;     // arbiter to sequencer
	image_sel_t    seq_image;
	reboot_cause_t last_cause; // arbiter back to regs
	logic          busy;       // sequencer to regs and arbiter

	wb_reprog_regs regs_i (
		.clk, .reset,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .wb_dat_r, .wb_ack,
		.busy, .last_cause, .host_req, .host_image, .wdt_enable
	);

	boot_watchdog wdt_i (
		.clk, .reset, .enable(wdt_enable), .heartbeat, .wdt_expire
	);

	reprog_arbiter arb_i (
		.clk, .reset, .host_req, .host_image, .wdt_expire, .busy,
		.seq_go, .seq_image, .last_cause
	);

	icap_sequencer seq_i (
		.clk, .reset, .seq_go, .seq_image, .busy, .icap_csib, .icap_data
	);

endmodule

// File: hdl/wb_reprog_regs.sv
`include "reprog_defs.svh"

module wb_reprog_regs import reprog_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	// wishbone classic slave
	input  logic          wb_cyc,
	input  logic          wb_stb,
	input  logic          wb_we,
	input  logic [1:0]    wb_adr,
	input  logic [31:0]   wb_dat_w,
	input  logic [3:0]    wb_sel,
	output logic [31:0]   wb_dat_r,
	output logic          wb_ack,
	// status from the core
	input  logic          busy,
	input  reboot_cause_t last_cause,
	// control to the core
	output logic          host_req,
	output image_sel_t    host_image,
	output logic          wdt_enable
);

	// ====================
	// bus decode
	// ====================
	logic        wb_open;  // transfer waiting for its ack
	logic        ctrl_wr;  // write hitting CTRL byte 0
	logic [31:0] rd_data;  // read mux output

	assign wb_open = wb_cyc & wb_stb & ~wb_ack; // one ack per strobe
	assign ctrl_wr = wb_open & wb_we & (wb_adr == `REPROG_ADR_CTRL) & wb_sel[0];

	always_comb begin
		rd_data = 32'd0; // unmapped reads zero
		case (wb_adr)
			`REPROG_ADR_CTRL:   rd_data[2] = wdt_enable; // only enable reads back
			`REPROG_ADR_STATUS: rd_data = {29'd0, last_cause, busy};
			default:            rd_data = 32'd0;
		endcase
	end

	// ====================
	// ack and registers
	// ====================
	// registers load on the edge that raises ack, so they hold the new
	// value during the ack cycle and host_req lines up with ack
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack     <= 1'b0;
			host_req   <= 1'b0;
			host_image <= IMAGE_GOLDEN;
			wdt_enable <= 1'b0; // watchdog off out of reset
		end else begin
			wb_ack   <= wb_open; // single wait cycle
			host_req <= 1'b0;    // pulse by default
			if (ctrl_wr) begin
				host_req   <= wb_dat_w[0];               // reboot request
				host_image <= image_sel_t'(wb_dat_w[1]); // 1 = master
				wdt_enable <= wb_dat_w[2];
			end
		end
	end

	// read data sampled with the ack
	always_ff @(posedge clk) begin
		if (wb_open) begin
			wb_dat_r <= rd_data;
		end
	end

	// ====================
	// checks
	// ====================
	a_ack_open: assert property (@(posedge clk) disable iff (reset)
		wb_ack |-> wb_cyc && wb_stb)
		else $error("wb_ack raised after the master dropped its strobe");

endmodule

// File: tb/reprog_tb.sv
`include "reprog_defs.svh"

module reprog_tb import reprog_pkg::*; ();

	localparam int WDT       = `REPROG_WDT_CYCLES;
	localparam int SCENARIOS = 20;
	localparam int LIMIT     = SCENARIOS * (10 + 4 * WDT + 60); // reset, heartbeats, starve, bus

	logic        clk = 1'b0;
	logic        reset, wb_cyc, wb_stb, wb_we, heartbeat; // driven on falling edge
	logic [1:0]  wb_adr;
	logic [31:0] wb_dat_w, wb_dat_r, icap_data;
	logic [3:0]  wb_sel;
	logic        wb_ack, icap_csib;
	logic [31:0] words[$];                // ICAP words in normal bit order
	int          errors = 0, checks = 0, cycles = 0;

	reprog_top dut_i (.*);

	always #2 clk = ~clk; // period 4

	// ====================
	// run limit and ICAP monitor
	// ====================
	always @(posedge clk) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("timeout, run went past %0d cycles", LIMIT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	always @(negedge clk) begin
		if (reset)
			words.delete();                     // new scenario, new capture
		else if (!icap_csib)
			words.push_back(byte_mirror(icap_data)); // undo per-byte swap
	end

	// ====================
	// reference model
	// ====================
	function automatic logic [31:0] byte_mirror(input logic [31:0] d);
		logic [31:0] r;
		for (int i = 0; i < 32; i++)
			r[i] = d[(i & ~7) + 7 - (i & 7)]; // bit k of a byte goes to 7-k
		return r;
	endfunction

	function automatic logic [31:0] expected_word(input int idx, input image_sel_t img);
		case (idx)
			0: return `REPROG_ICAP_DUMMY;
			1: return `REPROG_ICAP_SYNC;
			2: return `REPROG_ICAP_NOOP;
			3: return `REPROG_ICAP_WRITE_WBSTAR;
			4: return {8'h00, (img == IMAGE_MASTER) ? `REPROG_MASTER_ADDR : `REPROG_GOLDEN_ADDR};
			5: return `REPROG_ICAP_WRITE_CMD;
			6: return `REPROG_ICAP_IPROG;
			default: return `REPROG_ICAP_NOOP; // trailing noop
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_sequence(input image_sel_t img);
		check("icap word count", 32'd8, words.size());
		foreach (words[i])
			if (i < 8) check($sformatf("icap word %0d", i), expected_word(i, img), words[i]);
	endtask

	// ====================
	// drivers
	// ====================
	task automatic apply_reset();
		reset     = 1'b1;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = 2'd0;
		wb_dat_w  = 32'd0;
		wb_sel    = 4'h0;
		heartbeat = 1'b0;
		repeat (10) @(negedge clk);
		reset = 1'b0;
	endtask

	// one classic cycle, held through the ack cycle like a master that samples
	// ack on the rising edge, so a second ack for the same strobe would show
	task automatic wb_cycle(input logic we, input logic [1:0] adr, input logic [31:0] dat,
			output logic [31:0] rdata);
		int n = 0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		wb_sel   = 4'hF;
		do begin
			@(negedge clk);
			n++;
		end while (!wb_ack && n < 8);
		if (!wb_ack) begin
			errors++;
			$display("no wishbone ack for address %0d", adr);
		end
		rdata = wb_dat_r;
		@(negedge clk);
		check("wb_ack", 32'd0, 32'(wb_ack)); // one ack per strobe
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wait_select(input int bound);
		bit seen;
		seen = 1'b0;
		for (int i = 0; i < bound && !seen; i++) begin
			@(negedge clk);
			seen = !icap_csib;
		end
		if (!seen) begin
			errors++;
			$display("icap_csib did not fall within %0d cycles", bound);
		end
	endtask

	// ====================
	// scenarios
	// ====================
	initial begin
		image_sel_t    img, exp_img;
		reboot_cause_t exp_cause;
		logic [31:0]   rd;
		logic [1:0]    adr;
		int            kind, off, gap, t;
		void'($urandom(53850));
		for (int s = 0; s < SCENARIOS; s++) begin
			apply_reset();
			wb_cycle(1'b0, `REPROG_ADR_STATUS, 32'd0, rd);
			check("status", 32'd0, rd);                      // idle, no cause
			check("icap_data", `REPROG_ICAP_DUMMY, byte_mirror(icap_data));
			repeat (5) @(negedge clk);
			check("icap_csib", 32'd1, 32'(icap_csib));       // quiet without request
			kind = $urandom_range(0, 2);
			img  = $urandom_range(0, 1) ? IMAGE_MASTER : IMAGE_GOLDEN;
			case (kind)
				0: begin // host reboot, watchdog off
					wb_cycle(1'b1, `REPROG_ADR_CTRL, {29'd0, 1'b0, img, 1'b1}, rd);
					exp_img   = img;
					exp_cause = CAUSE_HOST;
				end
				1: begin // heartbeats keep it alive, then starve
					wb_cycle(1'b1, `REPROG_ADR_CTRL, 32'h4, rd);
					wb_cycle(1'b0, `REPROG_ADR_CTRL, 32'd0, rd);
					check("ctrl", 32'h4, rd);                  // enable reads back
					t = 0;
					while (t < 2 * WDT) begin
						gap = $urandom_range(1, WDT / 2);       // well under the timeout
						repeat (gap) @(negedge clk);
						heartbeat = 1'b1;
						@(negedge clk);
						heartbeat = 1'b0;
						t += gap + 1;
					end
					check("icap words while fed", 32'd0, words.size());
					exp_img   = IMAGE_GOLDEN;
					exp_cause = CAUSE_WATCHDOG;
				end
				default: begin // host write lands near the expiry pulse
					wb_cycle(1'b1, `REPROG_ADR_CTRL, 32'h4, rd);
					off = int'($urandom_range(0, 4)) - 2;     // host_req relative to wdt_expire
					repeat (WDT - 2 + off) @(negedge clk);
					wb_cycle(1'b1, `REPROG_ADR_CTRL, {29'd0, 1'b1, img, 1'b1}, rd);
					exp_img   = (off < 0) ? img : IMAGE_GOLDEN; // tie goes to watchdog
					exp_cause = (off < 0) ? CAUSE_HOST : CAUSE_WATCHDOG;
				end
			endcase
			wait_select(WDT + 20);
			repeat (12) @(negedge clk);                    // let the burst finish
			check_sequence(exp_img);
			wb_cycle(1'b0, `REPROG_ADR_STATUS, 32'd0, rd);
			check("status", {29'd0, exp_cause, 1'b1}, rd); // busy stays up
			// a later request must not start a second burst
			wb_cycle(1'b1, `REPROG_ADR_CTRL, {29'd0, 1'b0, ~img, 1'b1}, rd);
			repeat (10) @(negedge clk);
			check("icap word count", 32'd8, words.size());
			adr = $urandom_range(0, 1) ? 2'd3 : 2'd2;      // unmapped space
			wb_cycle(1'b1, adr, $urandom, rd);
			adr = $urandom_range(0, 1) ? 2'd3 : 2'd2;
			wb_cycle(1'b0, adr, 32'd0, rd);
			check("unmapped read", 32'd0, rd);
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
